// File: hdl/rvPkg.sv
// Encodings cover only lw, sw, beq and the listed R/I ALU ops; both memories share MEM_WORDS
package rvPkg;

  localparam int XLEN      = 32;
  localparam int MEM_WORDS = 64;
  localparam int ADDR_BITS = $clog2(MEM_WORDS);  // Word index bits into either memory

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      regAddr_t;

  // Opcodes of the supported instruction classes
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opRtype  = 7'b0110011;
  localparam logic [6:0] opItype  = 7'b0010011;
  localparam logic [6:0] opBranch = 7'b1100011;

  // ALU operation select
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,  // Also used by beq for the zero test
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4   // Signed compare
  } aluCtrl_t;

  // Immediate format
  typedef enum logic [1:0] {
    immI = 2'd0,
    immS = 2'd1,
    immB = 2'd2
  } immSel_t;

  // Forwarding source for an execute operand
  typedef enum logic [1:0] {
    fwdNone = 2'd0,  // Register file value
    fwdWb   = 2'd1,  // Writeback result
    fwdMem  = 2'd2   // ALU result in memory stage
  } fwdSel_t;

endpackage

// File: hdl/pipeControl.sv
// Unknown opcodes decode as no-ops; the load-use check may stall on rs2 bits of an I-type word
`timescale 1ns/1ns

module pipeControl (
  input  logic              clk,
  input  logic              reset,
  input  logic [6:0]        opD,
  input  logic [2:0]        funct3D,
  input  logic              funct7b5D,
  input  rvPkg::regAddr_t   rs1D,
  input  rvPkg::regAddr_t   rs2D,
  input  rvPkg::regAddr_t   rs1E,
  input  rvPkg::regAddr_t   rs2E,
  input  rvPkg::regAddr_t   rdE,
  input  rvPkg::regAddr_t   rdM,
  input  rvPkg::regAddr_t   rdW,
  input  logic              zeroE,
  output rvPkg::immSel_t    immSelD,
  output rvPkg::aluCtrl_t   aluCtrlE,
  output logic              aluSrcE,
  output logic              pcSrcE,
  output rvPkg::fwdSel_t    forwardAE,
  output rvPkg::fwdSel_t    forwardBE,
  output logic              stallF,
  output logic              stallD,
  output logic              flushD,
  output logic              flushE,
  output logic              memWriteM,
  output logic              regWriteW,
  output logic              memToRegW
);
  import rvPkg::*;

  aluCtrl_t functAluD, aluCtrlD;
  logic     regWriteD, memWriteD, memToRegD, branchD, aluSrcD;
  logic     regWriteE, memWriteE, memToRegE, branchE;
  logic     regWriteM, memToRegM;
  logic     lwStall;

  // Memory stage wins over writeback since it holds the newer value
  function automatic fwdSel_t pickFwd(regAddr_t rs, regAddr_t rdMem, logic wrMem,
                                      regAddr_t rdWb, logic wrWb);
    if (rs != '0 && rs == rdMem && wrMem) return fwdMem;
    if (rs != '0 && rs == rdWb && wrWb)   return fwdWb;
    return fwdNone;
  endfunction

  always_comb begin
    case (funct3D)
      3'b000:  functAluD = (funct7b5D && opD == opRtype) ? aluSub : aluAdd;
      3'b010:  functAluD = aluSlt;
      3'b110:  functAluD = aluOr;
      3'b111:  functAluD = aluAnd;
      default: functAluD = aluAdd;
    endcase
  end

  // Main decoder, everything low unless the opcode is known
  always_comb begin
    regWriteD = 1'b0;
    memWriteD = 1'b0;
    memToRegD = 1'b0;
    branchD   = 1'b0;
    aluSrcD   = 1'b0;
    immSelD   = immI;
    aluCtrlD  = aluAdd;
    case (opD)
      opLoad:   begin regWriteD = 1'b1; aluSrcD = 1'b1; memToRegD = 1'b1; end
      opStore:  begin memWriteD = 1'b1; aluSrcD = 1'b1; immSelD = immS; end
      opRtype:  begin regWriteD = 1'b1; aluCtrlD = functAluD; end
      opItype:  begin regWriteD = 1'b1; aluSrcD = 1'b1; aluCtrlD = functAluD; end
      opBranch: begin branchD = 1'b1; immSelD = immB; aluCtrlD = aluSub; end
      default:  ;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset || flushE) begin // Bubble into execute
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      branchE   <= 1'b0;
      aluSrcE   <= 1'b0;
      aluCtrlE  <= aluAdd;
    end else begin
      regWriteE <= regWriteD;
      memWriteE <= memWriteD;
      memToRegE <= memToRegD;
      branchE   <= branchD;
      aluSrcE   <= aluSrcD;
      aluCtrlE  <= aluCtrlD;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
    end else begin
      regWriteM <= regWriteE;
      memWriteM <= memWriteE;
      memToRegM <= memToRegE;
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
    end
  end

  assign pcSrcE    = branchE & zeroE;  // beq taken
  assign forwardAE = pickFwd(rs1E, rdM, regWriteM, rdW, regWriteW);
  assign forwardBE = pickFwd(rs2E, rdM, regWriteM, rdW, regWriteW);

  // Load result not ready until writeback, so hold decode one cycle
  assign lwStall = memToRegE && (rdE == rs1D || rdE == rs2D);
  assign stallF  = lwStall;
  assign stallD  = lwStall;
  assign flushD  = pcSrcE;
  assign flushE  = lwStall | pcSrcE;

endmodule

// File: hdl/fetchStage.sv
// ROM image read from bench/program.hex relative to the run directory; PC wraps inside 64 words
`timescale 1ns/1ns

module fetchStage (
  input  logic         clk,
  input  logic         reset,
  input  logic         stallF,
  input  logic         stallD,
  input  logic         flushD,
  input  logic         pcSrcE,
  input  rvPkg::word_t pcTargetE,
  output rvPkg::word_t instrD,
  output rvPkg::word_t pcD
);
  import rvPkg::*;

  word_t pcF, pcNextF, instrF;
  word_t rom [MEM_WORDS];

  initial begin
    $readmemh("bench/program.hex", rom);
  end

  assign pcNextF = pcSrcE ? pcTargetE : pcF + word_t'(4);
  assign instrF  = rom[pcF[ADDR_BITS+1:2]];  // Word addressed

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pcF <= '0;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  // Fetch/decode register, a cleared word is opcode 0 and decodes as a no-op
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      instrD <= '0;
      pcD    <= '0;
    end else if (flushD) begin
      instrD <= '0;
      pcD    <= '0;
    end else if (!stallD) begin
      instrD <= instrF;
      pcD    <= pcF;
    end
  end

endmodule

// File: hdl/decodeStage.sv
// Register file writes on the falling edge so decode sees a same-cycle writeback; x0 reads zero
`timescale 1ns/1ns

module decodeStage (
  input  logic            clk,
  input  logic            reset,
  input  logic            flushE,
  input  rvPkg::word_t    instrD,
  input  rvPkg::word_t    pcD,
  input  rvPkg::immSel_t  immSelD,
  input  logic            regWriteW,
  input  rvPkg::regAddr_t rdW,
  input  rvPkg::word_t    resultW,
  output rvPkg::word_t    rd1E,
  output rvPkg::word_t    rd2E,
  output rvPkg::word_t    immE,
  output rvPkg::word_t    pcE,
  output rvPkg::regAddr_t rs1E,
  output rvPkg::regAddr_t rs2E,
  output rvPkg::regAddr_t rdE
);
  import rvPkg::*;

  word_t    regs [32];
  word_t    rd1D, rd2D, immD;
  regAddr_t rs1D, rs2D, rdD;

  assign rs1D = instrD[19:15];
  assign rs2D = instrD[24:20];
  assign rdD  = instrD[11:7];

  always_ff @(negedge clk) begin
    if (regWriteW) regs[rdW] <= resultW;
  end

  assign rd1D = (rs1D != '0) ? regs[rs1D] : '0;
  assign rd2D = (rs2D != '0) ? regs[rs2D] : '0;

  always_comb begin
    case (immSelD)
      immI:    immD = {{20{instrD[31]}}, instrD[31:20]};
      immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
      immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
      default: immD = '0;
    endcase
  end

  // Decode/execute register
  always_ff @(posedge clk or posedge reset) begin
    if (reset || flushE) begin
      rd1E <= '0;
      rd2E <= '0;
      immE <= '0;
      pcE  <= '0;
      rs1E <= '0;
      rs2E <= '0;
      rdE  <= '0;
    end else begin
      rd1E <= rd1D;
      rd2E <= rd2D;
      immE <= immD;
      pcE  <= pcD;
      rs1E <= rs1D;
      rs2E <= rs2D;
      rdE  <= rdD;
    end
  end

endmodule

// File: hdl/executeStage.sv
// ALU covers add, sub, and, or and signed slt only; the branch target is always pcE plus immE
`timescale 1ns/1ns

module executeStage (
  input  logic             clk,
  input  logic             reset,
  input  rvPkg::word_t     rd1E,
  input  rvPkg::word_t     rd2E,
  input  rvPkg::word_t     immE,
  input  rvPkg::word_t     pcE,
  input  rvPkg::regAddr_t  rdE,
  input  rvPkg::fwdSel_t   forwardAE,
  input  rvPkg::fwdSel_t   forwardBE,
  input  logic             aluSrcE,
  input  rvPkg::aluCtrl_t  aluCtrlE,
  input  rvPkg::word_t     resultW,
  output logic             zeroE,
  output rvPkg::word_t     pcTargetE,
  output rvPkg::word_t     aluResultM,
  output rvPkg::word_t     writeDataM,
  output rvPkg::regAddr_t  rdM
);
  import rvPkg::*;

  word_t srcAE, srcBE, writeDataE, aluResultE;
  logic  lessE;

  function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t wbVal,
                                   word_t memVal);
    case (sel)
      fwdWb:   return wbVal;
      fwdMem:  return memVal;
      default: return regVal;
    endcase
  endfunction

  assign srcAE      = fwdMux(forwardAE, rd1E, resultW, aluResultM);
  assign writeDataE = fwdMux(forwardBE, rd2E, resultW, aluResultM);  // Also the store data
  assign srcBE      = aluSrcE ? immE : writeDataE;

  assign lessE = $signed(srcAE) < $signed(srcBE);

  always_comb begin
    case (aluCtrlE)
      aluAdd:  aluResultE = srcAE + srcBE;
      aluSub:  aluResultE = srcAE - srcBE;
      aluAnd:  aluResultE = srcAE & srcBE;
      aluOr:   aluResultE = srcAE | srcBE;
      aluSlt:  aluResultE = {{(XLEN-1){1'b0}}, lessE};
      default: aluResultE = srcAE + srcBE;
    endcase
  end

  assign zeroE     = (aluResultE == '0);
  assign pcTargetE = pcE + immE;

  // Execute/memory register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      aluResultM <= '0;
      writeDataM <= '0;
      rdM        <= '0;
    end else begin
      aluResultM <= aluResultE;
      writeDataM <= writeDataE;
      rdM        <= rdE;
    end
  end

endmodule

// File: hdl/memWriteback.sv
// Data RAM is word aligned with the low two address bits ignored; reads are combinational
`timescale 1ns/1ns

module memWriteback (
  input  logic            clk,
  input  logic            reset,
  input  logic            memWriteM,
  input  rvPkg::word_t    aluResultM,
  input  rvPkg::word_t    writeDataM,
  input  rvPkg::regAddr_t rdM,
  input  logic            memToRegW,
  output rvPkg::word_t    resultW,
  output rvPkg::regAddr_t rdW
);
  import rvPkg::*;

  word_t ram [MEM_WORDS];
  word_t readDataM, readDataW, aluResultW;

  assign readDataM = ram[aluResultM[ADDR_BITS+1:2]];

  always_ff @(posedge clk) begin
    if (memWriteM) ram[aluResultM[ADDR_BITS+1:2]] <= writeDataM;
  end

  // Memory/writeback register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      aluResultW <= '0;
      readDataW  <= '0;
      rdW        <= '0;
    end else begin
      aluResultW <= aluResultM;
      readDataW  <= readDataM;
      rdW        <= rdM;
    end
  end

  assign resultW = memToRegW ? readDataW : aluResultW;  // Loads take the RAM word

endmodule

// File: hdl/rvPipeline.sv
// Self-contained core with internal ROM and RAM; the outputs expose only the memory-stage store
`timescale 1ns/1ns

module rvPipeline (
  input  logic         clk,
  input  logic         reset,
  output rvPkg::word_t writeData,
  output rvPkg::word_t dataAdr,
  output logic         memWrite
);
  import rvPkg::*;

  word_t    instrD, pcD, rd1E, rd2E, immE, pcE, pcTargetE, resultW;
  regAddr_t rs1E, rs2E, rdE, rdM, rdW;
  immSel_t  immSelD;
  aluCtrl_t aluCtrlE;
  fwdSel_t  forwardAE, forwardBE;
  logic     aluSrcE, pcSrcE, zeroE;
  logic     stallF, stallD, flushD, flushE;
  logic     regWriteW, memToRegW;

  // Decode-stage fields are sliced straight out of the fetch/decode register
  pipeControl control (
    .clk(clk), .reset(reset),
    .opD(instrD[6:0]), .funct3D(instrD[14:12]), .funct7b5D(instrD[30]),
    .rs1D(instrD[19:15]), .rs2D(instrD[24:20]),
    .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE), .rdM(rdM), .rdW(rdW), .zeroE(zeroE),
    .immSelD(immSelD), .aluCtrlE(aluCtrlE), .aluSrcE(aluSrcE), .pcSrcE(pcSrcE),
    .forwardAE(forwardAE), .forwardBE(forwardBE),
    .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
    .memWriteM(memWrite), .regWriteW(regWriteW), .memToRegW(memToRegW)
  );

  fetchStage fetch (
    .clk(clk), .reset(reset), .stallF(stallF), .stallD(stallD), .flushD(flushD),
    .pcSrcE(pcSrcE), .pcTargetE(pcTargetE), .instrD(instrD), .pcD(pcD)
  );

  decodeStage decode (
    .clk(clk), .reset(reset), .flushE(flushE), .instrD(instrD), .pcD(pcD),
    .immSelD(immSelD), .regWriteW(regWriteW), .rdW(rdW), .resultW(resultW),
    .rd1E(rd1E), .rd2E(rd2E), .immE(immE), .pcE(pcE),
    .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE)
  );

  // Memory-stage address and store data double as the top-level outputs
  executeStage execute (
    .clk(clk), .reset(reset), .rd1E(rd1E), .rd2E(rd2E), .immE(immE), .pcE(pcE),
    .rdE(rdE), .forwardAE(forwardAE), .forwardBE(forwardBE), .aluSrcE(aluSrcE),
    .aluCtrlE(aluCtrlE), .resultW(resultW), .zeroE(zeroE), .pcTargetE(pcTargetE),
    .aluResultM(dataAdr), .writeDataM(writeData), .rdM(rdM)
  );

  memWriteback memWb (
    .clk(clk), .reset(reset), .memWriteM(memWrite), .aluResultM(dataAdr),
    .writeDataM(writeData), .rdM(rdM), .memToRegW(memToRegW),
    .resultW(resultW), .rdW(rdW)
  );

endmodule

// File: bench/rvPipeline_assert.sv
// Control checks apply only out of reset and probe the execute-stage control bits of pipeControl
`timescale 1ns/1ns

module rvPipelineAssert (
  input logic       clk,
  input logic       reset,
  input logic [6:0] opD,
  input logic       stallD,
  input logic       flushD,
  input logic       regWriteE,
  input logic       memWriteE,
  input logic       branchE,
  input logic       memWriteM
);
  int failCount;

  initial failCount = 0;

  // A held decode stage leaves a bubble behind it
  stallFlushes: assert property (@(posedge clk) disable iff (reset)
                                 stallD |=> (!regWriteE && !memWriteE && !branchE))
    else begin
      failCount++;
      $error("stallD high but execute did not get a bubble");
    end

  // Taken branch kills both younger instructions
  branchFlushes: assert property (@(posedge clk) disable iff (reset)
                                  flushD |=> (opD == 7'd0 && !regWriteE && !memWriteE &&
                                              !branchE))
    else begin
      failCount++;
      $error("flushD high but decode and execute were not cleared");
    end

  storeKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(memWriteM))
    else begin
      failCount++;
      $error("memWriteM is unknown");
    end

endmodule

bind pipeControl rvPipelineAssert checks (
  .clk(clk), .reset(reset), .opD(opD), .stallD(stallD), .flushD(flushD),
  .regWriteE(regWriteE), .memWriteE(memWriteE), .branchE(branchE),
  .memWriteM(memWriteM)
);

// File: bench/rvPipelineTb.sv
// Expects bench/program.hex to hold the store sequence of storeTable; run from the project root
`timescale 1ns/1ns

module rvPipelineTb;
  import rvPkg::*;

  localparam time clkPeriod = 40;
  localparam int  progWords = 28;  // Instruction words in program.hex
  localparam int  numStores = 10;

  // Expected stores in program order, address in the upper half, data in the lower
  localparam logic [63:0] storeTable [numStores] = '{
    {32'h40, 32'd17},  // add with forwarding from both stages
    {32'h44, 32'd7},
    {32'h48, 32'd0},
    {32'h4c, 32'd13},
    {32'h50, 32'd1},
    {32'h54, 32'd0},   // slti against -3
    {32'h58, 32'd34},  // Only right with the load-use bubble
    {32'h5c, 32'd99},  // Skipped store of 77 must not show up first
    {32'h64, 32'd0},   // x0 write discarded
    {32'h60, 32'd25}
  };

  logic  clk;
  logic  reset;
  word_t writeData;
  word_t dataAdr;
  logic  memWrite;

  rvPipeline i_dut (
    .clk(clk), .reset(reset), .writeData(writeData), .dataAdr(dataAdr), .memWrite(memWrite)
  );

  always #(clkPeriod / 2) clk = ~clk;

  task automatic compareValue(input string what, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Generous bound on cycles per instruction word
  initial begin
    #(progWords * 8 * clkPeriod);
    $display("Watchdog expired, the program did not finish its stores");
    $display("TEST FAILED");
    $fatal(1, "Timeout");
  end

  always @(negedge clk) begin
    if (i_dut.control.checks.failCount != 0) begin
      $display("A control assertion failed inside the DUT");
      $display("TEST FAILED");
      $fatal(1, "Assertion failure");
    end
  end

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    for (int i = 0; i < numStores; i++) begin
      @(negedge clk);
      while (memWrite !== 1'b1) @(negedge clk);  // Outputs settle well before the falling edge
      compareValue($sformatf("store %0d address", i), dataAdr, storeTable[i][63:32]);
      compareValue($sformatf("store %0d data", i), writeData, storeTable[i][31:0]);
    end
    if (i_dut.control.checks.failCount != 0) begin
      $display("A control assertion failed inside the DUT");
      $display("TEST FAILED");
      $fatal(1, "Assertion failure");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// File: bench/program.hex
// One RV32I instruction word per line, starting at address 0
00500093
00C00113
002081B3
04302023
40110233
04402223
0021F2B3
04502423
0020E333
04602623
0020A3B3
04702823
FFD0A413
04802A23
04002483
00948533
04A02C23
00108663
04D00593
04B02E23
00208463
06300613
04C02E23
03700013
06002223
01900693
06D02023
00000063

// File: sim.f
hdl/rvPkg.sv
hdl/pipeControl.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memWriteback.sv
hdl/rvPipeline.sv
bench/rvPipeline_assert.sv
bench/rvPipelineTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
if ! verilator --binary --timing --assert --top-module rvPipelineTb -f sim.f -o simv; then
  echo "Verilator build failed"
  exit 1
fi
if ! ./obj_dir/simv +verilator+error+limit+100; then
  echo "Simulation failed"
  exit 1
fi
exit 0
